/* source/pio_mem_pkg.sv */
// Memory geometry only; banks are cut to 1024 words, so address bits 15 to 10 are ignored
`default_nettype none

package pio_mem_pkg;

  // ------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------
  localparam int bank_count = 8;
  localparam int bank_words = 1024;

  // Bank index sits in the host address above the 64K-word aperture
  localparam int bank_lsb = 16;
  localparam int bank_msb = 18;
  localparam int offset_msb = 9;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  // Data word and PIO-layer address
  typedef logic [31:0] word_t;
  typedef logic [20:0] addr_t;
  // One enable per byte lane
  typedef logic [3:0]  be_t;
  typedef logic [2:0]  bank_sel_t;
  // Word offset inside a shortened bank
  typedef logic [offset_msb:0] offset_t;

endpackage

`default_nettype wire

/* source/pio_mbox_pkg.sv */
// Mailbox layout; upper half belongs to the host, lower half to the engine, count of zero copies nothing
`default_nettype none

package pio_mbox_pkg;

  // Reserved address, compared against address bits 18 to 0
  localparam logic [18:0] mbox_addr = 19'h7fffe;

  // ------------------------------------------------------------
  // Host-owned command half
  // ------------------------------------------------------------
  localparam int start_bit = 31;
  localparam int src_msb = 30;
  localparam int src_lsb = 28;
  localparam int dst_msb = 26;
  localparam int dst_lsb = 24;
  localparam int count_msb = 23;
  localparam int count_lsb = 16;
  localparam int count_w = count_msb - count_lsb + 1;

  // ------------------------------------------------------------
  // Engine-owned status half
  // ------------------------------------------------------------
  localparam int done_bit = 15;
  localparam int sum_msb = 14;
  localparam int sum_lsb = 0;
  localparam int sum_w = sum_msb - sum_lsb + 1;

  typedef logic [15:0] flag_half_t;

endpackage

`default_nettype wire

/* source/pio_host_port.sv */
// Host side decode; wr_en must be a one-cycle pulse and stay low for the two busy cycles after it
`timescale 1ns/1ps
`default_nettype none

module pio_host_port
  import pio_mem_pkg::*, pio_mbox_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire addr_t     rd_addr,
  input  wire addr_t     wr_addr,
  input  wire be_t       wr_be,
  input  wire word_t     wr_data,
  input  wire logic      wr_en,
  output logic           wr_busy,
  output be_t            host_bank_we [bank_count],
  output bank_sel_t      host_bank_sel,
  output offset_t        host_offset,
  output word_t          host_wdata,
  output logic           mbox_we,
  output word_t          mbox_wdata,
  output logic           mbox_rd_hit
);

  typedef enum logic [1:0] {idle, busy0, busy1} busy_state_t;

  busy_state_t state;
  busy_state_t state_next;
  addr_t       req_addr;
  logic        mbox_hit;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  // Write address wins while a write is presented
  assign req_addr = wr_en ? wr_addr : rd_addr;

  assign host_bank_sel = req_addr[bank_msb:bank_lsb];
  // Bits 15 to 10 dropped with the short banks
  assign host_offset   = req_addr[offset_msb:0];
  assign mbox_hit      = (req_addr[18:0] == mbox_addr);

  assign host_wdata = wr_data;
  assign mbox_wdata = wr_data;
  // Mailbox writes never reach memory
  assign mbox_we    = wr_en & mbox_hit;

  always_comb begin
    for (int b = 0; b < bank_count; b++) begin
      host_bank_we[b] = '0;
    end
    // Steer enables to the addressed bank only
    if (wr_en && !mbox_hit) begin
      host_bank_we[host_bank_sel] = wr_be;
    end
  end

  // ------------------------------------------------------------
  // Write-busy sequencer
  // ------------------------------------------------------------
  always_comb begin
    unique case (state)
      idle:    state_next = wr_en ? busy0 : idle;
      busy0:   state_next = busy1;
      busy1:   state_next = idle;
      default: state_next = idle;
    endcase
  end

  // Busy covers the two cycles after the write edge
  assign wr_busy = (state != idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= idle;
      mbox_rd_hit <= 1'b0;
    end else begin
      state       <= state_next;
      // Lines up with the registered bank read
      mbox_rd_hit <= mbox_hit;
    end
  end

  // Host must not issue a write during busy
  a_no_write_while_busy : assert property (
    @(posedge clk) disable iff (!rst_n) wr_busy |-> !wr_en
  ) else $error("host write issued while wr_busy high");

endmodule

`default_nettype wire

/* source/pio_bank_ram.sv */
// Behavioral true dual-port bank; same-offset writes from both ports in one cycle leave port b's bytes
`timescale 1ns/1ps
`default_nettype none

module pio_bank_ram
  import pio_mem_pkg::*;
(
  input  wire logic    clk,
  // Port a, host side
  input  wire be_t     a_we,
  input  wire offset_t a_offset,
  input  wire word_t   a_wdata,
  output word_t        a_rdata,
  // Port b, engine side
  input  wire be_t     b_we,
  input  wire offset_t b_offset,
  input  wire word_t   b_wdata,
  output word_t        b_rdata
);

  word_t mem [bank_words];

  // ------------------------------------------------------------
  // Byte-lane writes and registered reads
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < $bits(be_t); i++) begin
      if (a_we[i]) begin
        mem[a_offset][i*8 +: 8] <= a_wdata[i*8 +: 8];
      end
    end
    for (int i = 0; i < $bits(be_t); i++) begin
      if (b_we[i]) begin
        mem[b_offset][i*8 +: 8] <= b_wdata[i*8 +: 8];
      end
    end
    // Read-before-write on both ports
    a_rdata <= mem[a_offset];
    b_rdata <= mem[b_offset];
  end

endmodule

`default_nettype wire

/* source/pio_mem_array.sv */
// Eight banks; host owns port a and the engine port b, with no arbitration between them
`timescale 1ns/1ps
`default_nettype none

module pio_mem_array
  import pio_mem_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire be_t       host_bank_we [bank_count],
  input  wire bank_sel_t host_bank_sel,
  input  wire offset_t   host_offset,
  input  wire word_t     host_wdata,
  output word_t          host_rdata,
  input  wire bank_sel_t user_bank_sel,
  input  wire offset_t   user_offset,
  input  wire word_t     user_wdata,
  input  wire logic      user_we,
  output word_t          user_rdata
);

  be_t       user_bank_we [bank_count];
  word_t     host_bank_rdata [bank_count];
  word_t     user_bank_rdata [bank_count];
  bank_sel_t host_sel_q;
  bank_sel_t user_sel_q;
  logic [bank_count-1:0] host_we_any;

  // ------------------------------------------------------------
  // Bank instances
  // ------------------------------------------------------------
  for (genvar b = 0; b < bank_count; b++) begin : g_bank
    // Engine always writes whole words
    assign user_bank_we[b] = (user_we && user_bank_sel == bank_sel_t'(b)) ? '1 : '0;
    assign host_we_any[b]  = |host_bank_we[b];

    pio_bank_ram u_bank (
      .clk      (clk),
      .a_we     (host_bank_we[b]),
      .a_offset (host_offset),
      .a_wdata  (host_wdata),
      .a_rdata  (host_bank_rdata[b]),
      .b_we     (user_bank_we[b]),
      .b_offset (user_offset),
      .b_wdata  (user_wdata),
      .b_rdata  (user_bank_rdata[b])
    );
  end

  // ------------------------------------------------------------
  // Read steering
  // ------------------------------------------------------------
  // Selects delayed to match the RAM output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_sel_q <= '0;
      user_sel_q <= '0;
    end else begin
      host_sel_q <= host_bank_sel;
      user_sel_q <= user_bank_sel;
    end
  end

  assign host_rdata = host_bank_rdata[host_sel_q];
  assign user_rdata = user_bank_rdata[user_sel_q];

  // Decode in the host port must hit one bank at most
  a_host_we_onehot : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(host_we_any)
  ) else $error("host write enables reach more than one bank");

endmodule

`default_nettype wire

/* source/pio_mailbox.sv */
// Flag register; a same-cycle engine update overrides the host data on the lower half only
`timescale 1ns/1ps
`default_nettype none

module pio_mailbox
  import pio_mem_pkg::*, pio_mbox_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       mbox_we,
  input  wire word_t      mbox_wdata,
  input  wire logic       mbox_rd_hit,
  input  wire word_t      host_rdata,
  input  wire logic       user_flag_we,
  input  wire flag_half_t user_flag_half,
  output word_t           flags,
  output word_t           rd_data
);

  localparam int half_w = $bits(flag_half_t);

  word_t flags_next;

  // ------------------------------------------------------------
  // Update merge
  // ------------------------------------------------------------
  always_comb begin
    flags_next = flags;
    // Host replaces the whole word
    if (mbox_we) begin
      flags_next = mbox_wdata;
    end
    // Engine status then lands on top
    if (user_flag_we) begin
      flags_next[half_w-1:0] = user_flag_half;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      flags <= flags_next;
    end
  end

  // Hit flag already carries the one-cycle read latency
  assign rd_data = mbox_rd_hit ? flags : host_rdata;

endmodule

`default_nettype wire

/* source/pio_user_engine.sv */
// Copy engine; a new command needs start_bit to go low and high again, and is ignored while busy
`timescale 1ns/1ps
`default_nettype none

module pio_user_engine
  import pio_mem_pkg::*, pio_mbox_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire word_t flags,
  output bank_sel_t  user_bank_sel,
  output offset_t    user_offset,
  output logic       user_we,
  output word_t      user_wdata,
  input  wire word_t user_rdata,
  output logic       user_flag_we,
  output flag_half_t user_flag_half
);

  typedef enum logic [1:0] {eng_idle, eng_clear, eng_copy, eng_done} eng_state_t;

  eng_state_t         state;
  logic               start_q;
  logic               start_rise;
  bank_sel_t          src_bank;
  bank_sel_t          dst_bank;
  logic [count_w-1:0] count;
  logic [count_w-1:0] rd_idx;
  logic [count_w-1:0] wr_idx;
  word_t              hold;
  logic               hold_valid;
  logic               rd_pend;
  logic [sum_w-1:0]   sum;
  logic               do_read;
  logic               do_write;
  logic               copy_end;

  // ------------------------------------------------------------
  // Port schedule
  // ------------------------------------------------------------
  assign start_rise = flags[start_bit] & ~start_q;

  // A held word always goes out before the next read
  assign do_write = (state == eng_copy) && hold_valid;
  assign do_read  = (state == eng_copy) && !hold_valid && (rd_idx != count);
  // All written, nothing held, nothing returning from the bank
  assign copy_end = (wr_idx == count) && !hold_valid && !rd_pend;

  assign user_we       = do_write;
  assign user_bank_sel = do_write ? dst_bank : src_bank;
  // Same offset on both sides of the copy
  assign user_offset   = offset_t'(do_write ? wr_idx : rd_idx);
  // Byte reversal on the way out
  assign user_wdata    = {hold[7:0], hold[15:8], hold[23:16], hold[31:24]};

  // Status writes: clear at start, done plus sum at end
  assign user_flag_we = (state == eng_clear) || (state == eng_done);

  always_comb begin
    user_flag_half = '0;
    if (state == eng_done) begin
      user_flag_half[done_bit]        = 1'b1;
      user_flag_half[sum_msb:sum_lsb] = sum;
    end
  end

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= eng_idle;
      start_q    <= 1'b0;
      src_bank   <= '0;
      dst_bank   <= '0;
      count      <= '0;
      rd_idx     <= '0;
      wr_idx     <= '0;
      hold_valid <= 1'b0;
      rd_pend    <= 1'b0;
      sum        <= '0;
    end else begin
      start_q <= flags[start_bit];
      // Bank data shows up one cycle after the read
      rd_pend <= do_read;
      case (state)
        eng_idle: begin
          if (start_rise) begin
            src_bank <= flags[src_msb:src_lsb];
            dst_bank <= flags[dst_msb:dst_lsb];
            count    <= flags[count_msb:count_lsb];
            state    <= eng_clear;
          end
        end
        eng_clear: begin
          rd_idx     <= '0;
          wr_idx     <= '0;
          hold_valid <= 1'b0;
          sum        <= '0;
          state      <= eng_copy;
        end
        eng_copy: begin
          if (do_read) begin
            rd_idx <= rd_idx + 1'b1;
          end
          if (do_write) begin
            wr_idx <= wr_idx + 1'b1;
          end
          // Sum taken from the source word as it arrives
          if (rd_pend) begin
            sum <= sum + user_rdata[sum_w-1:0];
          end
          // Second word may land while the first is written
          hold_valid <= rd_pend | (hold_valid & ~do_write);
          if (copy_end) begin
            state <= eng_done;
          end
        end
        eng_done: state <= eng_idle;
        default:  state <= eng_idle;
      endcase
    end
  end

  // Word capture register
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      hold <= user_rdata;
    end
  end

  // Clear and done writes never land back to back
  a_flag_we_gap : assert property (
    @(posedge clk) disable iff (!rst_n) user_flag_we |=> !user_flag_we
  ) else $error("user_flag_we high on consecutive cycles");

endmodule

`default_nettype wire

/* source/pio_ep_mem.sv */
// Endpoint memory top; single clock domain, rd_be is accepted for the PIO interface but never masks data
`timescale 1ns/1ps
`default_nettype none

module pio_ep_mem
  import pio_mem_pkg::*, pio_mbox_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  // Read access
  input  wire addr_t rd_addr,
  input  wire be_t   rd_be,
  output word_t      rd_data,
  // Write access
  input  wire addr_t wr_addr,
  input  wire be_t   wr_be,
  input  wire word_t wr_data,
  input  wire logic  wr_en,
  output logic       wr_busy
);

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------
  be_t        host_bank_we [bank_count];
  bank_sel_t  host_bank_sel;
  offset_t    host_offset;
  word_t      host_wdata;
  word_t      host_rdata;
  logic       mbox_we;
  word_t      mbox_wdata;
  logic       mbox_rd_hit;
  word_t      flags;
  bank_sel_t  user_bank_sel;
  offset_t    user_offset;
  logic       user_we;
  word_t      user_wdata;
  word_t      user_rdata;
  logic       user_flag_we;
  flag_half_t user_flag_half;

  pio_host_port u_host_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_addr       (rd_addr),
    .wr_addr       (wr_addr),
    .wr_be         (wr_be),
    .wr_data       (wr_data),
    .wr_en         (wr_en),
    .wr_busy       (wr_busy),
    .host_bank_we  (host_bank_we),
    .host_bank_sel (host_bank_sel),
    .host_offset   (host_offset),
    .host_wdata    (host_wdata),
    .mbox_we       (mbox_we),
    .mbox_wdata    (mbox_wdata),
    .mbox_rd_hit   (mbox_rd_hit)
  );

  pio_mem_array u_mem_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_bank_we  (host_bank_we),
    .host_bank_sel (host_bank_sel),
    .host_offset   (host_offset),
    .host_wdata    (host_wdata),
    .host_rdata    (host_rdata),
    .user_bank_sel (user_bank_sel),
    .user_offset   (user_offset),
    .user_wdata    (user_wdata),
    .user_we       (user_we),
    .user_rdata    (user_rdata)
  );

  pio_mailbox u_mailbox (
    .clk            (clk),
    .rst_n          (rst_n),
    .mbox_we        (mbox_we),
    .mbox_wdata     (mbox_wdata),
    .mbox_rd_hit    (mbox_rd_hit),
    .host_rdata     (host_rdata),
    .user_flag_we   (user_flag_we),
    .user_flag_half (user_flag_half),
    .flags          (flags),
    .rd_data        (rd_data)
  );

  pio_user_engine u_user_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .flags          (flags),
    .user_bank_sel  (user_bank_sel),
    .user_offset    (user_offset),
    .user_we        (user_we),
    .user_wdata     (user_wdata),
    .user_rdata     (user_rdata),
    .user_flag_we   (user_flag_we),
    .user_flag_half (user_flag_half)
  );

endmodule

`default_nettype wire

/* testbench/pio_tb_tasks.svh */
// Included inside pio_ep_mem_tb; every task starts and ends on a falling clock edge
`ifndef PIO_TB_TASKS_SVH
`define PIO_TB_TASKS_SVH

// ------------------------------------------------------------
// Address and model helpers
// ------------------------------------------------------------
// Bits 15 to 10 left zero, so bank 7 offset 3fe is plain memory
function automatic addr_t make_addr(input bank_sel_t bank, input offset_t offset);
  addr_t a;
  a = '0;
  a[bank_msb:bank_lsb] = bank;
  a[offset_msb:0] = offset;
  return a;
endfunction

function automatic addr_t mbox_host_addr();
  addr_t a;
  a = '0;
  a[18:0] = mbox_addr;
  return a;
endfunction

function automatic int shadow_idx(input bank_sel_t bank, input offset_t offset);
  return int'(bank) * bank_words + int'(offset);
endfunction

// Enabled lanes take new data
function automatic word_t merge_bytes(input word_t old, input word_t data, input be_t be);
  word_t r;
  r = old;
  for (int k = 0; k < 4; k++) begin
    if (be[k]) r[8*k +: 8] = data[8*k +: 8];
  end
  return r;
endfunction

// Lane k of the result is lane 3-k of the source
function automatic word_t reverse_bytes(input word_t w);
  word_t r;
  for (int k = 0; k < 4; k++) begin
    r[8*k +: 8] = w[8*(3-k) +: 8];
  end
  return r;
endfunction

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic check_word(input string name, input word_t got, input word_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input flag_half_t got, input flag_half_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("CHECK FAILED at %0t: %s got %04h expected %04h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

// ------------------------------------------------------------
// Host drive
// ------------------------------------------------------------
// One-cycle write pulse, then busy must cover exactly two cycles
task automatic host_write(input addr_t addr, input be_t be, input word_t data);
  wr_addr = addr;
  wr_be   = be;
  wr_data = data;
  wr_en   = 1'b1;
  @(negedge clk);
  wr_en = 1'b0;
  check_bit("wr_busy cycle 1", wr_busy, 1'b1);
  @(negedge clk);
  check_bit("wr_busy cycle 2", wr_busy, 1'b1);
  @(negedge clk);
  check_bit("wr_busy cycle 3", wr_busy, 1'b0);
endtask

// Data valid one cycle after the address
task automatic host_read(input addr_t addr, output word_t data);
  rd_addr = addr;
  rd_be   = 4'hf;
  @(negedge clk);
  data = rd_data;
endtask

task automatic store_word(input bank_sel_t bank, input offset_t offset, input be_t be,
                          input word_t data);
  host_write(make_addr(bank, offset), be, data);
  shadow[shadow_idx(bank, offset)] = merge_bytes(shadow[shadow_idx(bank, offset)], data, be);
endtask

task automatic compare_readback(input bank_sel_t bank, input offset_t offset, input string what);
  word_t got;
  host_read(make_addr(bank, offset), got);
  check_word($sformatf("%s bank %0d offset %03h", what, bank, offset), got,
             shadow[shadow_idx(bank, offset)]);
endtask

// Poll the mailbox until the engine reports done
task automatic wait_done(output word_t flags_seen);
  int polls;
  polls = 0;
  host_read(mbox_host_addr(), flags_seen);
  while (!flags_seen[done_bit] && polls < poll_limit) begin
    host_read(mbox_host_addr(), flags_seen);
    polls++;
  end
  if (!flags_seen[done_bit]) begin
    error_count++;
    $display("Copy engine did not report done within %0d mailbox polls", poll_limit);
  end
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic reset_defaults();
  word_t got;
  check_bit("wr_busy after reset", wr_busy, 1'b0);
  host_read(mbox_host_addr(), got);
  check_word("flags after reset", got, '0);
endtask

// Full word first, then a partial write over it
task automatic byte_lane_merge();
  int      touched [$];
  offset_t off;
  be_t     be;
  for (int b = 0; b < bank_count; b++) begin
    for (int n = 0; n < be_per_bank; n++) begin
      off = offset_t'($urandom_range(bank_words - 1));
      store_word(bank_sel_t'(b), off, 4'hf, $urandom());
      be = be_t'($urandom_range(14, 1));
      store_word(bank_sel_t'(b), off, be, $urandom());
      compare_readback(bank_sel_t'(b), off, "byte merge");
      touched.push_back(shadow_idx(bank_sel_t'(b), off));
    end
  end
  // Second pass catches a write that hit the wrong bank
  foreach (touched[i]) begin
    compare_readback(bank_sel_t'(touched[i] / bank_words),
                     offset_t'(touched[i] % bank_words), "reread");
  end
endtask

// Start bit kept low so the engine stays idle
task automatic mailbox_alias();
  word_t cmd;
  word_t got;
  store_word(3'd7, 10'h3fe, 4'hf, $urandom());
  cmd = $urandom();
  cmd[start_bit] = 1'b0;
  host_write(mbox_host_addr(), 4'hf, cmd);
  host_read(mbox_host_addr(), got);
  check_word("mailbox readback", got, cmd);
  compare_readback(3'd7, 10'h3fe, "word under mailbox");
endtask

task automatic block_copy(input bank_sel_t src, input bank_sel_t dst,
                          input logic [count_w-1:0] cnt);
  word_t cmd;
  word_t got;
  word_t sum_all;
  sum_all = '0;
  for (int i = 0; i < int'(cnt); i++) begin
    store_word(src, offset_t'(i), 4'hf, $urandom());
    sum_all = sum_all + shadow[shadow_idx(src, offset_t'(i))];
  end
  cmd = {1'b1, src, 1'b0, dst, cnt, 16'h0000};
  // Drop start first so the engine sees a fresh rising edge
  host_write(mbox_host_addr(), 4'hf, {1'b0, cmd[30:0]});
  host_write(mbox_host_addr(), 4'hf, cmd);
  wait_done(got);
  check_bit("done_bit", got[done_bit], 1'b1);
  check_flag("flags lower half", got[15:0], {1'b1, sum_all[sum_msb:sum_lsb]});
  check_flag("flags upper half", got[31:16], cmd[31:16]);
  for (int i = 0; i < int'(cnt); i++) begin
    shadow[shadow_idx(dst, offset_t'(i))] = reverse_bytes(shadow[shadow_idx(src, offset_t'(i))]);
    compare_readback(dst, offset_t'(i), "copied word");
  end
endtask

// Count zero must leave the destination alone
task automatic empty_copy(input bank_sel_t src, input bank_sel_t dst);
  for (int i = 0; i < 4; i++) begin
    store_word(dst, offset_t'(i), 4'hf, $urandom());
  end
  block_copy(src, dst, '0);
  for (int i = 0; i < 4; i++) begin
    compare_readback(dst, offset_t'(i), "untouched word");
  end
endtask

`endif

/* testbench/pio_ep_mem_tb.sv */
// Directed testbench; never writes a bank while the copy engine uses it, stimulus on falling edges
`timescale 1ns/1ps
`default_nettype none

module pio_ep_mem_tb
  import pio_mem_pkg::*, pio_mbox_pkg::*;
();

  // ------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------
  localparam int be_per_bank = 4;
  localparam int copy_runs   = 3;
  localparam int max_words   = 256;
  localparam int reset_cycles = 16;
  // Engine needs at most 4 cycles per word, one poll per cycle
  localparam int poll_limit  = max_words * 4 + 16;
  // Writes, reads and rereads of every test, rounded up
  localparam int total_ops   = bank_count * be_per_bank * 4
                             + (copy_runs + 1) * (2 * max_words + 8) + 32;
  localparam int engine_runs = copy_runs + 1;
  // Twice the expected length as margin
  localparam int watchdog_cycles =
    2 * (reset_cycles + total_ops * 8 + engine_runs * max_words * 4);

  // DUT pins
  logic  clk;
  logic  rst_n;
  addr_t rd_addr;
  be_t   rd_be;
  word_t rd_data;
  addr_t wr_addr;
  be_t   wr_be;
  word_t wr_data;
  logic  wr_en;
  logic  wr_busy;

  // Reference model of all banks, flat
  word_t       shadow [bank_count * bank_words];
  int          error_count;
  int          check_count;

  `include "pio_tb_tasks.svh"

  pio_ep_mem UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_addr (rd_addr),
    .rd_be   (rd_be),
    .rd_data (rd_data),
    .wr_addr (wr_addr),
    .wr_be   (wr_be),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .wr_busy (wr_busy)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Test order
  // ------------------------------------------------------------
  initial begin : test_sequence
    bank_sel_t          src;
    bank_sel_t          dst;
    logic [count_w-1:0] cnt;
    clk         = 1'b0;
    rst_n       = 1'b0;
    rd_addr     = '0;
    rd_be       = '0;
    wr_addr     = '0;
    wr_be       = '0;
    wr_data     = '0;
    wr_en       = 1'b0;
    error_count = 0;
    check_count = 0;
    void'($urandom(32'h46a8));
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    reset_defaults();
    byte_lane_merge();
    mailbox_alias();
    // Longest copy first, then random ones
    block_copy(3'd1, 3'd4, 8'd255);
    for (int r = 1; r < copy_runs; r++) begin
      src = bank_sel_t'($urandom_range(bank_count - 1));
      dst = bank_sel_t'((int'(src) + 1 + $urandom_range(bank_count - 2)) % bank_count);
      cnt = count_w'($urandom_range(254, 1));
      block_copy(src, dst, cnt);
    end
    empty_copy(3'd2, 3'd6);

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pio_ep_mem.f */
+incdir+testbench
source/pio_mem_pkg.sv
source/pio_mbox_pkg.sv
source/pio_host_port.sv
source/pio_bank_ram.sv
source/pio_mem_array.sv
source/pio_mailbox.sv
source/pio_user_engine.sv
source/pio_ep_mem.sv
testbench/pio_ep_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the endpoint memory testbench with Verilator.
# Exit status is nonzero on a build error, a simulator error, or a missing pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=pio_ep_mem_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module pio_ep_mem_tb -f pio_ep_mem.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build returned an error"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation executable returned status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
